//--- Makefile
# Verilator build and run of the traffic controller testbench
VERILATOR ?= verilator
TOP       ?= tb_traffic_controller
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
hdl/traffic_pkg.sv
hdl/phase_sequencer.sv
hdl/phase_timer.sv
hdl/walk_request_latch.sv
hdl/lamp_decoder.sv
hdl/walk_signal_driver.sv
hdl/traffic_controller.sv
verif/tb_traffic_controller.sv

//--- hdl/lamp_decoder.sv
`timescale 1ns/100ps

module lamp_decoder (
    input  traffic_pkg::phase_t phase,
    output logic                northbound_red,
    output logic                northbound_amber,
    output logic                northbound_green,
    output logic                southbound_red,
    output logic                southbound_amber,
    output logic                southbound_green,
    output logic                eastbound_red,
    output logic                eastbound_amber,
    output logic                eastbound_green,
    output logic                westbound_red,
    output logic                westbound_amber,
    output logic                westbound_green,
    output logic [1:0]          southbound_arrow
);

    import traffic_pkg::*;

    logic ew_go;
    logic ew_amber_on;
    logic ns_go;
    logic ns_amber_on;
    logic arrow_on;

    // Green families include walk, flash and clearance phases
    assign ew_go       = phase inside {EW_GREEN, EW_WALK, EW_FLASH, EW_CLEAR};
    assign ew_amber_on = (phase == EW_AMBER);
    assign ns_go       = phase inside {NS_GREEN, NS_WALK, NS_FLASH, NS_CLEAR};
    assign ns_amber_on = (phase == NS_AMBER);
    assign arrow_on    = (phase == NS_ARROW);

    assign eastbound_green  = ew_go;
    assign eastbound_amber  = ew_amber_on;
    assign eastbound_red    = !(ew_go || ew_amber_on);
    assign westbound_green  = ew_go;
    assign westbound_amber  = ew_amber_on;
    assign westbound_red    = !(ew_go || ew_amber_on);

    assign northbound_green = ns_go;
    assign northbound_amber = ns_amber_on;
    assign northbound_red   = !(ns_go || ns_amber_on);

    // Southbound holds amber while its turn arrow runs
    assign southbound_green = ns_go;
    assign southbound_amber = ns_amber_on || arrow_on;
    assign southbound_red   = !(ns_go || ns_amber_on || arrow_on);
    assign southbound_arrow = {2{arrow_on}};

endmodule

//--- hdl/phase_sequencer.sv
`timescale 1ns/100ps

module phase_sequencer (
    input  logic               clk,
    input  logic               reset_bar,
    input  logic               phase_last,
    input  logic               left_turn_request,
    input  logic               ns_pending,
    input  logic               ew_pending,
    output traffic_pkg::phase_t phase,
    output traffic_pkg::phase_t next_phase,
    output logic               phase_load,
    output logic               walk_ns_served,
    output logic               walk_ew_served
);

    import traffic_pkg::*;

    // Advance exactly on the last cycle of the running phase
    assign phase_load = phase_last;

    always_ff @(posedge clk or negedge reset_bar) begin
        if (!reset_bar) begin
            phase <= EW_GREEN;
        end else if (phase_load) begin
            phase <= next_phase;
        end
    end

    // Transition table
    always_comb begin
        case (phase)
            EW_GREEN:      next_phase = EW_AMBER;
            EW_WALK:       next_phase = EW_FLASH;
            EW_FLASH:      next_phase = EW_CLEAR;
            EW_CLEAR:      next_phase = EW_AMBER;
            EW_AMBER:      next_phase = ALL_RED_TO_NS;
            ALL_RED_TO_NS: begin
                // Left turn button is active low and takes priority
                if (!left_turn_request) begin
                    next_phase = NS_ARROW;
                end else if (ns_pending) begin
                    next_phase = NS_WALK;
                end else begin
                    next_phase = NS_GREEN;
                end
            end
            NS_ARROW: begin
                if (ns_pending) begin
                    next_phase = NS_WALK;
                end else begin
                    next_phase = NS_GREEN;
                end
            end
            NS_GREEN:      next_phase = NS_AMBER;
            NS_WALK:       next_phase = NS_FLASH;
            NS_FLASH:      next_phase = NS_CLEAR;
            NS_CLEAR:      next_phase = NS_AMBER;
            NS_AMBER:      next_phase = ALL_RED_TO_EW;
            ALL_RED_TO_EW: begin
                if (ew_pending) begin
                    next_phase = EW_WALK;
                end else begin
                    next_phase = EW_GREEN;
                end
            end
            default:       next_phase = EW_GREEN;
        endcase
    end

    // Serve pulses clear the pending request as its walk phase starts
    assign walk_ns_served = phase_load && (next_phase == NS_WALK);
    assign walk_ew_served = phase_load && (next_phase == EW_WALK);

endmodule

//--- hdl/phase_timer.sv
`timescale 1ns/100ps

module phase_timer #(
    parameter int GREEN_CYCLES   = traffic_pkg::GREEN_CYCLES_DEF,
    parameter int WALK_CYCLES    = traffic_pkg::WALK_CYCLES_DEF,
    parameter int FLASH_CYCLES   = traffic_pkg::FLASH_CYCLES_DEF,
    parameter int CLEAR_CYCLES   = traffic_pkg::CLEAR_CYCLES_DEF,
    parameter int AMBER_CYCLES   = traffic_pkg::AMBER_CYCLES_DEF,
    parameter int ALL_RED_CYCLES = traffic_pkg::ALL_RED_CYCLES_DEF,
    parameter int ARROW_CYCLES   = traffic_pkg::ARROW_CYCLES_DEF
) (
    input  logic                clk,
    input  logic                reset_bar,
    input  logic                phase_load,
    input  traffic_pkg::phase_t next_phase,
    output logic                phase_last
);

    import traffic_pkg::*;

    logic [TIMER_W-1:0] count;
    logic [TIMER_W-1:0] load_value;

    // Duration of the phase about to start
    always_comb begin
        case (next_phase)
            EW_WALK, NS_WALK:             load_value = TIMER_W'(WALK_CYCLES);
            EW_FLASH, NS_FLASH:           load_value = TIMER_W'(FLASH_CYCLES);
            EW_CLEAR, NS_CLEAR:           load_value = TIMER_W'(CLEAR_CYCLES);
            EW_AMBER, NS_AMBER:           load_value = TIMER_W'(AMBER_CYCLES);
            ALL_RED_TO_NS, ALL_RED_TO_EW: load_value = TIMER_W'(ALL_RED_CYCLES);
            NS_ARROW:                     load_value = TIMER_W'(ARROW_CYCLES);
            default:                      load_value = TIMER_W'(GREEN_CYCLES);
        endcase
    end

    // Reset phase is EW_GREEN, so start with the green duration
    always_ff @(posedge clk or negedge reset_bar) begin
        if (!reset_bar) begin
            count <= TIMER_W'(GREEN_CYCLES);
        end else if (phase_load) begin
            count <= load_value;
        end else begin
            count <= count - 1'b1;
        end
    end

    assign phase_last = (count == TIMER_W'(1));

endmodule

//--- hdl/traffic_controller.sv
`timescale 1ns/100ps

module traffic_controller #(
    parameter int GREEN_CYCLES   = traffic_pkg::GREEN_CYCLES_DEF,
    parameter int WALK_CYCLES    = traffic_pkg::WALK_CYCLES_DEF,
    parameter int FLASH_CYCLES   = traffic_pkg::FLASH_CYCLES_DEF,
    parameter int CLEAR_CYCLES   = traffic_pkg::CLEAR_CYCLES_DEF,
    parameter int AMBER_CYCLES   = traffic_pkg::AMBER_CYCLES_DEF,
    parameter int ALL_RED_CYCLES = traffic_pkg::ALL_RED_CYCLES_DEF,
    parameter int ARROW_CYCLES   = traffic_pkg::ARROW_CYCLES_DEF,
    parameter int FLASH_HALF     = traffic_pkg::FLASH_HALF_DEF
) (
    input  logic       clk,
    input  logic       reset_bar,
    // Push-buttons, active low
    input  logic       left_turn_request,
    input  logic       walk_ns_request,
    input  logic       walk_ew_request,
    // Lamps, active high
    output logic       northbound_red,
    output logic       northbound_amber,
    output logic       northbound_green,
    output logic [5:0] northbound_walk_light,
    output logic       eastbound_red,
    output logic       eastbound_amber,
    output logic       eastbound_green,
    output logic [5:0] eastbound_walk_light,
    output logic       southbound_red,
    output logic       southbound_amber,
    output logic       southbound_green,
    output logic [5:0] southbound_walk_light,
    output logic [1:0] southbound_arrow,
    output logic       westbound_red,
    output logic       westbound_amber,
    output logic       westbound_green,
    output logic [5:0] westbound_walk_light
);

    import traffic_pkg::*;

    phase_t phase;
    phase_t next_phase;
    logic   phase_load;
    logic   phase_last;
    logic   walk_ns_served;
    logic   walk_ew_served;
    logic   ns_pending;
    logic   ew_pending;

    phase_sequencer u_sequencer (
        .clk, .reset_bar, .phase_last, .left_turn_request, .ns_pending, .ew_pending,
        .phase, .next_phase, .phase_load, .walk_ns_served, .walk_ew_served
    );

    phase_timer #(
        .GREEN_CYCLES(GREEN_CYCLES), .WALK_CYCLES(WALK_CYCLES),
        .FLASH_CYCLES(FLASH_CYCLES), .CLEAR_CYCLES(CLEAR_CYCLES),
        .AMBER_CYCLES(AMBER_CYCLES), .ALL_RED_CYCLES(ALL_RED_CYCLES),
        .ARROW_CYCLES(ARROW_CYCLES)
    ) u_timer (
        .clk, .reset_bar, .phase_load, .next_phase, .phase_last
    );

    walk_request_latch u_request_latch (
        .clk, .reset_bar, .walk_ns_request, .walk_ew_request,
        .walk_ns_served, .walk_ew_served, .ns_pending, .ew_pending
    );

    lamp_decoder u_lamps (
        .phase,
        .northbound_red, .northbound_amber, .northbound_green,
        .southbound_red, .southbound_amber, .southbound_green,
        .eastbound_red, .eastbound_amber, .eastbound_green,
        .westbound_red, .westbound_amber, .westbound_green,
        .southbound_arrow
    );

    walk_signal_driver #(
        .FLASH_HALF(FLASH_HALF)
    ) u_walk (
        .clk, .reset_bar, .phase,
        .northbound_walk_light, .southbound_walk_light,
        .eastbound_walk_light, .westbound_walk_light
    );

endmodule

//--- hdl/traffic_pkg.sv
package traffic_pkg;

    // Signal phases of the intersection
    typedef enum logic [3:0] {
        EW_GREEN,
        EW_WALK,
        EW_FLASH,
        EW_CLEAR,
        EW_AMBER,
        ALL_RED_TO_NS,
        NS_ARROW,
        NS_GREEN,
        NS_WALK,
        NS_FLASH,
        NS_CLEAR,
        NS_AMBER,
        ALL_RED_TO_EW
    } phase_t;

    // Phase timer width, enough for durations up to 63
    localparam int TIMER_W = 6;

    // Default phase durations in clock cycles
    localparam int GREEN_CYCLES_DEF   = 60;
    localparam int WALK_CYCLES_DEF    = 10;
    localparam int FLASH_CYCLES_DEF   = 20;
    localparam int CLEAR_CYCLES_DEF   = 30;
    localparam int AMBER_CYCLES_DEF   = 6;
    localparam int ALL_RED_CYCLES_DEF = 2;
    localparam int ARROW_CYCLES_DEF   = 20;
    localparam int FLASH_HALF_DEF     = 2;

    // Walk display segments, hand on bit 5, walker on bits 4..0
    localparam logic [5:0] WALK_SHOW      = 6'b011111;
    localparam logic [5:0] DONT_WALK_SHOW = 6'b100000;
    localparam logic [5:0] WALK_DARK      = 6'b000000;

endpackage

//--- hdl/walk_request_latch.sv
`timescale 1ns/100ps

module walk_request_latch (
    input  logic clk,
    input  logic reset_bar,
    input  logic walk_ns_request,
    input  logic walk_ew_request,
    input  logic walk_ns_served,
    input  logic walk_ew_served,
    output logic ns_pending,
    output logic ew_pending
);

    // Buttons are active low; a press on the serving edge keeps the request
    always_ff @(posedge clk or negedge reset_bar) begin
        if (!reset_bar) begin
            ns_pending <= 1'b0;
        end else if (!walk_ns_request) begin
            ns_pending <= 1'b1;
        end else if (walk_ns_served) begin
            ns_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge reset_bar) begin
        if (!reset_bar) begin
            ew_pending <= 1'b0;
        end else if (!walk_ew_request) begin
            ew_pending <= 1'b1;
        end else if (walk_ew_served) begin
            ew_pending <= 1'b0;
        end
    end

endmodule

//--- hdl/walk_signal_driver.sv
`timescale 1ns/100ps

module walk_signal_driver #(
    parameter int FLASH_HALF = traffic_pkg::FLASH_HALF_DEF
) (
    input  logic                clk,
    input  logic                reset_bar,
    input  traffic_pkg::phase_t phase,
    output logic [5:0]          northbound_walk_light,
    output logic [5:0]          southbound_walk_light,
    output logic [5:0]          eastbound_walk_light,
    output logic [5:0]          westbound_walk_light
);

    import traffic_pkg::*;

    logic [TIMER_W-1:0] flash_cnt;
    logic               flash_on;
    logic               in_flash;
    logic [5:0]         flash_show;

    // Only one road can be flashing at a time, so one counter serves both
    assign in_flash = (phase == NS_FLASH) || (phase == EW_FLASH);

    always_ff @(posedge clk or negedge reset_bar) begin
        if (!reset_bar) begin
            flash_cnt <= '0;
            flash_on  <= 1'b0;
        end else if (!in_flash) begin
            flash_cnt <= '0;
            flash_on  <= 1'b0;
        end else if (flash_cnt == TIMER_W'(FLASH_HALF - 1)) begin
            flash_cnt <= '0;
            flash_on  <= !flash_on;
        end else begin
            flash_cnt <= flash_cnt + 1'b1;
        end
    end

    // Dark half first, then the hand
    assign flash_show = flash_on ? DONT_WALK_SHOW : WALK_DARK;

    assign northbound_walk_light = (phase == NS_WALK)  ? WALK_SHOW :
                                   (phase == NS_FLASH) ? flash_show : DONT_WALK_SHOW;
    assign southbound_walk_light = northbound_walk_light;
    assign eastbound_walk_light  = (phase == EW_WALK)  ? WALK_SHOW :
                                   (phase == EW_FLASH) ? flash_show : DONT_WALK_SHOW;
    assign westbound_walk_light  = eastbound_walk_light;

endmodule

//--- verif/tb_traffic_controller.sv
`timescale 1ns/100ps

module tb_traffic_controller;

    logic       clk;
    logic       reset_bar;
    logic       left_turn_request;
    logic       walk_ns_request;
    logic       walk_ew_request;
    logic       northbound_red, northbound_amber, northbound_green;
    logic       southbound_red, southbound_amber, southbound_green;
    logic       eastbound_red, eastbound_amber, eastbound_green;
    logic       westbound_red, westbound_amber, westbound_green;
    logic [1:0] southbound_arrow;
    logic [5:0] northbound_walk_light, southbound_walk_light;
    logic [5:0] eastbound_walk_light, westbound_walk_light;

    // One entry per stimulus row
    int          test_no[$];
    int          run_cycles[$];
    logic [25:0] row_data[$];
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          test_errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    bit          loaded;

    traffic_controller DUT (.*);

    always #2 clk = ~clk;

    // Limit is twice the cycles listed in the stimulus file
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic compare(input string what, input logic [7:0] actual,
                           input logic [7:0] expected);
        if (actual !== expected) begin
            $display("Error: time %0t: %s is %0h, expected %0h", $time, what, actual, expected);
            test_errors++;
        end
    endtask

    task automatic load_stimulus(output bit ok);
        int          fd;
        int          fields;
        int          num;
        int          cycles;
        string       line;
        logic        btn_left;
        logic        btn_ns;
        logic        btn_ew;
        logic [2:0]  exp_n, exp_e, exp_s;
        logic [1:0]  exp_arrow;
        logic [5:0]  exp_nwalk, exp_ewalk;
        ok = 0;
        fd = $fopen("verif/traffic_stim.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line[0] != "#") begin
                    fields = $sscanf(line, "%d %d %b %b %b %b %b %b %b %h %h", num, cycles,
                                     btn_left, btn_ns, btn_ew, exp_n, exp_e, exp_s,
                                     exp_arrow, exp_nwalk, exp_ewalk);
                    if (fields == 11) begin
                        test_no.push_back(num);
                        run_cycles.push_back(cycles);
                        row_data.push_back({btn_left, btn_ns, btn_ew, exp_n, exp_e, exp_s,
                                            exp_arrow, exp_nwalk, exp_ewalk});
                        cycle_limit += 2 * cycles;
                    end
                end
            end
            $fclose(fd);
            ok = (test_no.size() > 0);
        end
    endtask

    // Drive the buttons, run the cycles, then check the lamps
    task automatic run_row(input int i);
        logic [25:0] row;
        row = row_data[i];
        {left_turn_request, walk_ns_request, walk_ew_request} = row[25:23];
        repeat (run_cycles[i]) begin
            @(posedge clk);
            #1;
        end
        compare("north lamps", 8'({northbound_red, northbound_amber, northbound_green}),
                8'(row[22:20]));
        compare("east lamps", 8'({eastbound_red, eastbound_amber, eastbound_green}),
                8'(row[19:17]));
        compare("west lamps", 8'({westbound_red, westbound_amber, westbound_green}),
                8'(row[19:17]));
        compare("south lamps", 8'({southbound_red, southbound_amber, southbound_green}),
                8'(row[16:14]));
        compare("south arrow", 8'(southbound_arrow), 8'(row[13:12]));
        compare("north walk", 8'(northbound_walk_light), 8'(row[11:6]));
        compare("south walk", 8'(southbound_walk_light), 8'(row[11:6]));
        compare("east walk", 8'(eastbound_walk_light), 8'(row[5:0]));
        compare("west walk", 8'(westbound_walk_light), 8'(row[5:0]));
    endtask

    initial begin
        clk = 1'b0;
        reset_bar = 1'b0;
        left_turn_request = 1'b1;
        walk_ns_request = 1'b1;
        walk_ew_request = 1'b1;
        load_stimulus(loaded);
        if (!loaded) begin
            $display("Could not read any rows from verif/traffic_stim.txt");
            $display("Verification failed");
            $finish;
        end else begin
            repeat (3) @(posedge clk);
            #1 reset_bar = 1'b1;
            foreach (test_no[i]) begin
                run_row(i);
                // A test ends where the test number changes
                if (i == test_no.size() - 1 || test_no[i] != test_no[i + 1]) begin
                    if (test_errors == 0) begin
                        $display("Test %0d passed", test_no[i]);
                        tests_passed++;
                    end else begin
                        $display("Test %0d failed with %0d mismatches", test_no[i], test_errors);
                        tests_failed++;
                    end
                    test_errors = 0;
                end
            end
            $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
            if (tests_failed == 0) begin
                $display("Verification passed");
            end else begin
                $display("Verification failed");
            end
            $finish;
        end
    end

endmodule

//--- verif/traffic_stim.txt
# test cycles left_turn walk_ns walk_ew north(r a g) east(r a g) south(r a g) arrow
# north_walk east_walk (hex); buttons are held for the cycles, values checked after them
1 0  1 1 1 100 001 100 00 20 20
2 59 1 1 1 100 001 100 00 20 20
2 1  1 1 1 100 010 100 00 20 20
2 6  1 1 1 100 100 100 00 20 20
2 2  1 1 1 001 100 001 00 20 20
2 60 1 1 1 010 100 010 00 20 20
2 6  1 1 1 100 100 100 00 20 20
2 2  1 1 1 100 001 100 00 20 20
3 68 1 1 1 001 100 001 00 20 20
3 1  1 1 0 001 100 001 00 20 20
3 59 1 1 1 010 100 010 00 20 20
3 8  1 1 1 100 001 100 00 20 1f
3 10 1 1 1 100 001 100 00 20 00
3 2  1 1 1 100 001 100 00 20 20
3 3  1 1 1 100 001 100 00 20 00
3 10 1 1 1 100 001 100 00 20 20
3 5  1 1 1 100 001 100 00 20 20
3 30 1 1 1 100 010 100 00 20 20
3 6  1 1 1 100 100 100 00 20 20
4 2  0 0 1 100 100 010 11 20 20
4 19 1 1 1 100 100 010 11 20 20
4 1  1 1 1 001 100 001 00 1f 20
4 10 1 1 1 001 100 001 00 00 20
4 20 1 1 1 001 100 001 00 20 20
4 36 1 1 1 100 100 100 00 20 20
5 2  1 1 1 100 001 100 00 20 20
5 59 1 1 1 100 001 100 00 20 20
5 1  1 1 1 100 010 100 00 20 20
